// ==== fetch_pkg.sv ====
package fetch_pkg;

    // widths with a meaning
    typedef logic [31:0]  addr_t;
    typedef logic [31:0]  inst_t;
    typedef logic [63:0]  order_t;
    typedef logic [63:0]  beat_t;
    typedef logic [255:0] line_t;

    // first fetch address after reset
    localparam addr_t reset_pc = 32'haaaaa000;

    // memory beats per 256-bit line
    localparam int beats_per_line = 4;

    // default instruction queue depth
    localparam int queue_depth = 32;

    // one queue entry, order in the top bits
    typedef struct packed {
        order_t order;
        addr_t  pc;
        inst_t  inst;
    } fetch_entry_t;

    // fetch FSM
    //   serve   - hand out words from the line buffer
    //   request - hold the read until the memory takes it
    //   refill  - wait for the assembled line
    typedef enum logic [1:0] {
        serve,
        request,
        refill
    } fetch_state_t;

endpackage

// ==== line_assembler.sv ====
module line_assembler import fetch_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    input  beat_t mem_rdata_i,
    input  logic  mem_rvalid_i,

    output line_t line_o,
    output logic  line_valid_o
);

    logic [$clog2(beats_per_line)-1:0] beat_cnt;
    line_t                             line_q;
    logic                              last_beat;

    assign last_beat = mem_rvalid_i && (beat_cnt == beats_per_line - 1);

    // beats arrive lowest address first, so shifting in from the top
    // leaves beat k at bits 64k after the last one
    always_ff @(posedge clk) begin
        if (mem_rvalid_i) begin
            line_q <= {mem_rdata_i, line_q[$bits(line_t)-1:$bits(beat_t)]};
        end
    end

    // beat counter wraps on the last beat of a line
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (mem_rvalid_i) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // one-cycle pulse after the fourth beat
    always_ff @(posedge clk) begin
        if (rst) begin
            line_valid_o <= 1'b0;
        end else begin
            line_valid_o <= last_beat;
        end
    end

    assign line_o = line_q;

    // a line takes four beats, so two pulses can never touch
    a_single_pulse: assert property (
        @(posedge clk) disable iff (rst)
        line_valid_o |=> !line_valid_o
    ) else $error("line_valid_o high on two consecutive cycles");

endmodule

// ==== fetch_unit.sv ====
module fetch_unit import fetch_pkg::*; (
    input  logic         clk,
    input  logic         rst,

    // queue side
    input  logic         full_i,
    output logic         enq_o,
    output fetch_entry_t enq_entry_o,

    // from the line assembler
    input  line_t        line_i,
    input  logic         line_valid_i,

    // memory request
    input  logic         mem_ready_i,
    output addr_t        mem_addr_o,
    output logic         mem_read_o
);

    fetch_state_t state;

    addr_t  pc;
    order_t order;

    // line buffer tagged by the line address above the 32-byte offset
    logic         lb_valid;
    logic [26:0]  lb_tag;
    line_t        lb_data;

    logic  hit;
    inst_t word;

    assign hit = lb_valid && (lb_tag == pc[31:5]);

    // word index is pc[4:2]
    assign word = lb_data[pc[4:2]*$bits(inst_t) +: $bits(inst_t)];

    // enqueue straight from the buffer at one word per cycle
    assign enq_o             = (state == serve) && hit && !full_i;
    assign enq_entry_o.order = order;
    assign enq_entry_o.pc    = pc;
    assign enq_entry_o.inst  = word;

    // pc does not move outside serve, so the address holds during request
    assign mem_read_o = (state == request);
    assign mem_addr_o = {pc[31:5], 5'b0};

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= serve;
            pc       <= reset_pc;
            order    <= '0;
            lb_valid <= 1'b0;
        end else begin
            case (state)
                serve: begin
                    // a full queue holds everything including misses
                    if (!full_i) begin
                        if (hit) begin
                            pc    <= pc + 32'd4;
                            order <= order + 64'd1;
                        end else begin
                            state <= request;
                        end
                    end
                end
                request: begin
                    if (mem_ready_i) begin
                        state <= refill;
                    end
                end
                refill: begin
                    if (line_valid_i) begin
                        lb_valid <= 1'b1;
                        state    <= serve;
                    end
                end
                default: begin
                    state <= serve;
                end
            endcase
        end
    end

    // line buffer payload
    always_ff @(posedge clk) begin
        if ((state == refill) && line_valid_i) begin
            lb_tag  <= pc[31:5];
            lb_data <= line_i;
        end
    end

    // the request must stay put until the memory accepts it
    a_req_stable: assert property (
        @(posedge clk) disable iff (rst)
        (mem_read_o && !mem_ready_i) |=> (mem_read_o && $stable(mem_addr_o))
    ) else $error("memory request dropped or changed before mem_ready_i");

endmodule

// ==== inst_queue.sv ====
module inst_queue import fetch_pkg::*; #(
    parameter int depth = queue_depth
) (
    input  logic         clk,
    input  logic         rst,

    input  logic         enq_i,
    input  fetch_entry_t enq_entry_i,
    output logic         full_o,

    input  logic         deq_i,
    output fetch_entry_t deq_entry_o,
    output logic         deq_valid_o
);

    fetch_entry_t mem [depth];

    // pointers wrap on their own, depth is a power of two
    logic [$clog2(depth)-1:0] head;
    logic [$clog2(depth)-1:0] tail;
    logic [$clog2(depth):0]   count;

    logic push;
    logic pop;

    assign push = enq_i;
    // popping an empty queue is ignored
    assign pop  = deq_i && (count != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail] <= enq_entry_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            // both at once leaves the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign full_o      = (count == depth);
    assign deq_valid_o = (count != '0);
    assign deq_entry_o = mem[head];

    // the writer has to respect full_o, the queue does not drop entries
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        enq_i |-> !full_o
    ) else $error("enqueue into a full instruction queue");

endmodule

// ==== fetch_top.sv ====
module fetch_top import fetch_pkg::*; (
    input  logic         clk,
    input  logic         rst,

    // burst memory
    output addr_t        mem_addr_o,
    output logic         mem_read_o,
    input  logic         mem_ready_i,
    input  beat_t        mem_rdata_i,
    input  logic         mem_rvalid_i,

    // dequeue port
    input  logic         deq_i,
    output fetch_entry_t deq_entry_o,
    output logic         deq_valid_o
);

    line_t        line;
    logic         line_valid;
    logic         full;
    logic         enq;
    fetch_entry_t enq_entry;

    line_assembler line_assembler_inst (
        .clk          (clk),
        .rst          (rst),
        .mem_rdata_i  (mem_rdata_i),
        .mem_rvalid_i (mem_rvalid_i),
        .line_o       (line),
        .line_valid_o (line_valid)
    );

    fetch_unit fetch_unit_inst (
        .clk          (clk),
        .rst          (rst),
        .full_i       (full),
        .enq_o        (enq),
        .enq_entry_o  (enq_entry),
        .line_i       (line),
        .line_valid_i (line_valid),
        .mem_ready_i  (mem_ready_i),
        .mem_addr_o   (mem_addr_o),
        .mem_read_o   (mem_read_o)
    );

    inst_queue #(
        .depth        (queue_depth)
    ) inst_queue_inst (
        .clk          (clk),
        .rst          (rst),
        .enq_i        (enq),
        .enq_entry_i  (enq_entry),
        .full_o       (full),
        .deq_i        (deq_i),
        .deq_entry_o  (deq_entry_o),
        .deq_valid_o  (deq_valid_o)
    );

endmodule

// ==== tb_fetch.sv ====
module tb_fetch import fetch_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int total_entries   = 2000;
    localparam int stall_cycles    = 300;
    localparam int pop_wait_limit  = 500;
    localparam int mem_wait_limit  = 1000;
    localparam int words_per_line  = $bits(line_t) / $bits(inst_t);

    logic         clk          = 1'b0;
    logic         rst          = 1'b1;
    logic         mem_ready_i  = 1'b0;
    beat_t        mem_rdata_i  = '0;
    logic         mem_rvalid_i = 1'b0;
    logic         deq_i        = 1'b0;
    addr_t        mem_addr_o;
    logic         mem_read_o;
    fetch_entry_t deq_entry_o;
    logic         deq_valid_o;

    logic [31:0]  rand_state    = 32'd40839;
    addr_t        next_req_addr = reset_pc;
    int           accepted      = 0;
    int           popped        = 0;

    fetch_top fetch_top_inst (
        .clk          (clk),
        .rst          (rst),
        .mem_addr_o   (mem_addr_o),
        .mem_read_o   (mem_read_o),
        .mem_ready_i  (mem_ready_i),
        .mem_rdata_i  (mem_rdata_i),
        .mem_rvalid_i (mem_rvalid_i),
        .deq_i        (deq_i),
        .deq_entry_o  (deq_entry_o),
        .deq_valid_o  (deq_valid_o)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    // xorshift32
    function automatic logic [31:0] next_rand();
        rand_state = rand_state ^ (rand_state << 13);
        rand_state = rand_state ^ (rand_state >> 17);
        rand_state = rand_state ^ (rand_state << 5);
        return rand_state;
    endfunction

    // memory content at byte address a
    function automatic inst_t mem_word(input addr_t a);
        return a ^ 32'h13579bdf;
    endfunction

    // the n-th fetched word in program order
    function automatic fetch_entry_t expected_entry(input int n);
        fetch_entry_t e;
        e.order = order_t'(n);
        e.pc    = reset_pc + addr_t'(4 * n);
        e.inst  = mem_word(e.pc);
        return e;
    endfunction

    task automatic fail_run();
        $display("TB FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s", what);
        fail_run();
    endtask

    task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic compare_entry(input string name, input fetch_entry_t got,
                                 input fetch_entry_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    // one memory cycle with nothing on the bus, no new read allowed
    task automatic idle_cycle();
        @(negedge clk);
        mem_ready_i  = 1'b0;
        mem_rvalid_i = 1'b0;
        compare_bit("mem_read_o", mem_read_o, 1'b0);
    endtask

    // wait for a read and take it after a random number of cycles
    task automatic accept_request(output addr_t line_addr);
        int waited;
        bit taken;
        waited = 0;
        taken  = 0;
        while (!taken) begin
            @(negedge clk);
            mem_ready_i  = 1'b0;
            mem_rvalid_i = 1'b0;
            if (mem_read_o && (next_rand() % 2 == 0)) begin
                compare_addr("mem_addr_o", mem_addr_o, next_req_addr);
                mem_ready_i = 1'b1;
                taken       = 1;
            end else begin
                waited++;
                if (waited > mem_wait_limit) begin
                    report_timeout("no memory read was accepted within the wait limit");
                end
            end
        end
        line_addr     = next_req_addr;
        next_req_addr = next_req_addr + 32'd32;
        accepted++;
    endtask

    // four beats, lowest address first, random gaps between them
    task automatic send_line(input addr_t line_addr);
        int    gap;
        addr_t beat_addr;
        for (int k = 0; k < beats_per_line; k++) begin
            gap = next_rand() % 4;
            repeat (gap) idle_cycle();
            beat_addr = line_addr + addr_t'(8 * k);
            @(negedge clk);
            mem_ready_i = 1'b0;
            compare_bit("mem_read_o", mem_read_o, 1'b0);
            mem_rdata_i  = {mem_word(beat_addr + 32'd4), mem_word(beat_addr)};
            mem_rvalid_i = 1'b1;
        end
    endtask

    // pop one entry, taking each chance with pop_pct percent
    task automatic pop_entry(input int pop_pct);
        int          waited;
        bit          done;
        logic [31:0] r;
        waited = 0;
        done   = 0;
        while (!done) begin
            @(negedge clk);
            deq_i = 1'b0;
            r     = next_rand();
            if (deq_valid_o && (r % 100 < pop_pct)) begin
                compare_entry("deq_entry_o", deq_entry_o, expected_entry(popped));
                deq_i = 1'b1;
                done  = 1;
                popped++;
            end else begin
                // poke the empty queue now and then, it must ignore it
                if (!deq_valid_o) begin
                    deq_i = r[7];
                end
                waited++;
                if (waited > pop_wait_limit) begin
                    report_timeout("no entry appeared on the dequeue port");
                end
            end
        end
    endtask

    // hold off the consumer and count the lines fetched meanwhile
    task automatic stall_and_check();
        int lines_needed;
        lines_needed = (popped + queue_depth + words_per_line - 1) / words_per_line;
        repeat (stall_cycles) begin
            @(negedge clk);
            deq_i = 1'b0;
        end
        if (accepted > lines_needed + 1) begin
            $display("too many memory reads while the queue was full: %0d accepted, %0d needed",
                     accepted, lines_needed);
            fail_run();
        end
        if (accepted < lines_needed) begin
            $display("queue did not fill while dequeue was held off: %0d lines of %0d",
                     accepted, lines_needed);
            fail_run();
        end
    endtask

    initial begin : memory_model
        addr_t line_addr;
        int    delay;
        int    waited;
        waited = 0;
        while (rst) begin
            @(negedge clk);
            waited++;
            if (waited > mem_wait_limit) begin
                report_timeout("reset was never released");
            end
        end
        forever begin
            accept_request(line_addr);
            delay = next_rand() % 8;
            repeat (delay) idle_cycle();
            send_line(line_addr);
        end
    end

    initial begin : stimulus
        repeat (2) @(negedge clk);
        compare_bit("mem_read_o", mem_read_o, 1'b0);
        compare_bit("deq_valid_o", deq_valid_o, 1'b0);
        rst = 1'b0;

        // eager consumer first
        while (popped < 400) begin
            pop_entry(100);
        end
        // random consumer
        while (popped < 1200) begin
            pop_entry(50);
        end
        stall_and_check();
        // drain and keep going
        while (popped < total_entries) begin
            pop_entry(60);
        end
        @(negedge clk);
        deq_i = 1'b0;

        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== list.f ====
fetch_pkg.sv
line_assembler.sv
fetch_unit.sv
inst_queue.sv
fetch_top.sv
tb_fetch.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_fetch -f list.f -o tb_fetch; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_fetch > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "TB FAILED" "$log"; then
    echo "simulation reported a failure"
    exit 1
fi

if [ "$run_status" -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if ! grep -q "TB PASSED" "$log"; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0
